// File: verification/fx_unit_trace.txt
# issue:  valid unit opcode target ra imm is64 (all hex)
# expect: valid gpr_we gpr_addr value cr_we cr_field cr_bits(lt gt eq so) carry carry32
1 0 0e 03 0000000000001000 fff0 1  1 1 03 0000000000000ff0 0 0 0 0 0
1 0 0e 1f 0000000000000005 8000 1  1 1 1f ffffffffffff8005 0 0 0 0 0
1 0 0f 04 0000000100000000 8001 1  1 1 04 0000000080010000 0 0 0 0 0
1 0 0f 05 0000000000000000 1234 1  1 1 05 0000000012340000 0 0 0 0 0
1 0 07 06 0000000000000007 fffd 1  1 1 06 ffffffffffffffeb 0 0 0 0 0
1 0 07 07 0000000100000001 0010 1  1 1 07 0000001000000010 0 0 0 0 0
1 0 07 08 4000000000000000 0004 1  1 1 08 0000000000000000 0 0 0 0 0
1 0 0c 09 ffffffffffffffff 0001 1  1 1 09 0000000000000000 0 0 0 1 1
1 0 0c 0a 0000000000000010 0020 1  1 1 0a 0000000000000030 0 0 0 0 0
1 0 0c 0b 00000000ffffffff 0001 1  1 1 0b 0000000100000000 0 0 0 0 1
1 0 0e 0c 0000000000000000 0001 1  1 1 0c 0000000000000001 0 0 0 0 1
1 0 08 0d 0000000000000005 0003 1  1 1 0d fffffffffffffffe 0 0 0 0 0
1 0 08 0e 0000000000000003 0005 1  1 1 0e 0000000000000002 0 0 0 1 1
1 0 08 0f 0000000100000000 0000 1  1 1 0f ffffffff00000000 0 0 0 0 1
1 0 0d 10 0000000000000000 0000 1  1 1 10 0000000000000000 1 0 2 0 0
1 0 0d 11 0000000000000001 fffe 1  1 1 11 ffffffffffffffff 1 0 8 0 0
1 0 0d 12 000000007fffffff 0001 0  1 1 12 0000000080000000 1 0 8 0 0
1 0 0d 13 ffffffffffffffff 0002 0  1 1 13 0000000000000001 1 0 4 1 1
1 0 0b 0d fffffffffffffffe 0005 1  1 0 00 0000000000000000 1 3 8 1 1
1 0 0b 04 00000001fffffffe fffe 1  1 0 00 0000000000000000 1 1 2 1 1
1 0 0a 1d fffffffffffffffe 0005 1  1 0 00 0000000000000000 1 7 4 1 1
1 0 0a 08 ffffffff00000003 8000 1  1 0 00 0000000000000000 1 2 8 1 1
1 0 0b 14 0000000080000000 0001 1  1 0 00 0000000000000000 1 5 8 1 1
1 0 0a 01 000000000000ffff ffff 1  1 0 00 0000000000000000 1 0 2 1 1
1 0 1c 14 123456789abcdef0 ff0f 1  1 1 14 000000000000de00 1 0 4 1 1
1 0 1d 15 ffffffffffffffff 8000 0  1 1 15 0000000080000000 1 0 8 1 1
1 0 1c 16 00000000ffff0000 ffff 1  1 1 16 0000000000000000 1 0 2 1 1
1 0 18 17 f000000000000000 8001 1  1 1 17 f000000000008001 0 0 0 1 1
1 0 19 18 0000000000000001 ffff 1  1 1 18 00000000ffff0001 0 0 0 1 1
1 0 1a 19 00000000000000ff ff00 1  1 1 19 000000000000ffff 0 0 0 1 1
1 0 1b 1a ffffffffffffffff 8000 1  1 1 1a ffffffff7fffffff 0 0 0 1 1
1 1 0e 03 0000000000000001 0001 1  0 0 00 0000000000000000 0 0 0 0 0
1 0 1f 03 0000000000000001 0001 1  0 0 00 0000000000000000 0 0 0 0 0
0 0 0c 05 0000000000000000 0001 1  0 0 00 0000000000000000 0 0 0 0 0
1 0 0e 1b 0000000000000002 0003 1  1 1 1b 0000000000000005 0 0 0 1 1
1 0 0c 1c 8000000000000000 8000 1  1 1 1c 7fffffffffff8000 0 0 0 1 0
1 0 07 1d fffffffffffffffe fffe 1  1 1 1d 0000000000000004 0 0 0 1 0
1 2 0b 0d 0000000000000001 0001 1  0 0 00 0000000000000000 0 0 0 0 0

// File: src.f
+incdir+logic
logic/fx_pkg.sv
logic/fx_issue_decode.sv
logic/fx_alu.sv
logic/fx_writeback_format.sv
logic/fx_unit.sv
verification/fx_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fx_unit testbench with verilator and run it
# the run counts as passed only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module fx_unit_tb -o fx_unit_sim \
	&& ./obj_dir/fx_unit_sim | tee /dev/stderr | grep -q -x -F '** PASS **' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

exit 0

// File: verification/fx_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fx_defs.svh"

module fx_unit_tb;

	import fx_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_LINES    = 64;  // room for the trace
	localparam int PIPE_DEPTH   = 3;   // queued results before the oldest is due
	localparam int DRAIN_CYCLES = 2;   // idle issues that push the last results out

	logic                  clock;
	logic                  rst;
	logic                  issue_valid;
	fx_issue_t             issue;
	fx_writeback_t         wb;
	logic                  xer_so;

	// trace contents with one entry per instruction
	logic                  stim_valid  [0:MAX_LINES-1];
	fx_issue_t             stim_issue  [0:MAX_LINES-1];
	fx_writeback_t         stim_expect [0:MAX_LINES-1];
	int                    n_lines;
	int                    checks_done;
	int                    cycle_count;
	int                    cycle_limit;  // 0 until the trace is read
	fx_writeback_t         expect_q [$]; // oldest first

	fx_unit UUT (
		.clock_i       (clock),
		.rst_i         (rst),
		.issue_valid_i (issue_valid),
		.issue_i       (issue),
		.wb_o          (wb),
		.xer_so_o      (xer_so)
	);

	always #10 clock = ~clock; // 20 ns period

	////////////////////////////////////////////////////////////
	// failure and compare
	////////////////////////////////////////////////////////////

	task automatic end_with_failure();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [`FX_DATA_W-1:0] got,
		input logic [`FX_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			end_with_failure();
		end
	endtask

	// control bits on every line and the payload only where it is defined
	task automatic compare_writeback(input fx_writeback_t exp);
		check_value("wb_o.valid", 64'(wb.valid), 64'(exp.valid));
		check_value("wb_o.gpr_we", 64'(wb.gpr_we), 64'(exp.gpr_we));
		check_value("wb_o.cr_we", 64'(wb.cr_we), 64'(exp.cr_we));
		check_value("xer_so_o", 64'(xer_so), 64'(1'b0)); // SO stays clear without OE forms
		if (exp.valid) begin
			check_value("wb_o.carry", 64'(wb.carry), 64'(exp.carry));
			check_value("wb_o.carry32", 64'(wb.carry32), 64'(exp.carry32));
			check_value("wb_o.overflow", 64'(wb.overflow), 64'(1'b0));
			if (exp.gpr_we) begin
				check_value("wb_o.gpr_addr", 64'(wb.gpr_addr), 64'(exp.gpr_addr));
				check_value("wb_o.value", wb.value, exp.value);
			end
			if (exp.cr_we) begin
				check_value("wb_o.cr_field", 64'(wb.cr_field), 64'(exp.cr_field));
				check_value("wb_o.cr_bits", 64'(wb.cr_bits), 64'(exp.cr_bits));
			end
		end
		checks_done++;
	endtask

	////////////////////////////////////////////////////////////
	// trace file
	////////////////////////////////////////////////////////////

	task automatic read_trace();
		int                    fd;
		int                    code;
		int                    line_no;
		string                 line;
		logic [63:0]           v_f, unit_f, opc_f, tgt_f, ra_f, imm_f, is64_f;
		logic [63:0]           ev_f, we_f, addr_f, val_f, crwe_f, crf_f, crb_f, ca_f, ca32_f;
		fd = $fopen("verification/fx_unit_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file verification/fx_unit_trace.txt");
			end_with_failure();
		end
		n_lines = 0;
		line_no = 0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			if (line.len() > 1 && line.getc(0) != "#") begin // skip blanks and comments
				code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v_f, unit_f, opc_f, tgt_f, ra_f, imm_f, is64_f,
					ev_f, we_f, addr_f, val_f, crwe_f, crf_f, crb_f, ca_f, ca32_f);
				if (code != 16) begin
					$display("trace line %0d does not hold 16 fields", line_no);
					end_with_failure();
				end
				if (n_lines == MAX_LINES) begin
					$display("trace has more than %0d instructions", MAX_LINES);
					end_with_failure();
				end
				stim_valid[n_lines]            = v_f[0];
				stim_issue[n_lines].unit_code  = fx_unit_code_e'(unit_f[2:0]);
				stim_issue[n_lines].opcode     = opc_f[5:0];
				stim_issue[n_lines].target     = tgt_f[4:0];
				stim_issue[n_lines].ra         = ra_f;
				stim_issue[n_lines].imm        = imm_f[15:0];
				stim_issue[n_lines].is64       = is64_f[0];
				stim_expect[n_lines]           = '0;
				stim_expect[n_lines].valid     = ev_f[0];
				stim_expect[n_lines].gpr_we    = we_f[0];
				stim_expect[n_lines].gpr_addr  = addr_f[4:0];
				stim_expect[n_lines].value     = val_f;
				stim_expect[n_lines].cr_we     = crwe_f[0];
				stim_expect[n_lines].cr_field  = crf_f[2:0];
				stim_expect[n_lines].cr_bits   = crb_f[3:0];
				stim_expect[n_lines].carry     = ca_f[0];
				stim_expect[n_lines].carry32   = ca32_f[0];
				n_lines++;
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and checking
	////////////////////////////////////////////////////////////

	initial begin
		fx_writeback_t exp_wb;
		clock       = 1'b0;
		rst         = 1'b1;
		issue_valid = 1'b0;
		issue       = '0;
		checks_done = 0;
		cycle_count = 0;
		cycle_limit = 0;
		read_trace();
		cycle_limit = RESET_CYCLES + n_lines + 10;
		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0;
		for (int i = 0; i < n_lines + DRAIN_CYCLES; i++) begin
			if (i < n_lines) begin
				issue_valid <= stim_valid[i];
				issue       <= stim_issue[i];
				expect_q.push_back(stim_expect[i]);
			end else begin
				issue_valid <= 1'b0; // drain
				issue       <= '0;
				expect_q.push_back('0);
			end
			@(negedge clock); // wb_o settled mid cycle
			if (expect_q.size() == PIPE_DEPTH) begin
				exp_wb = expect_q.pop_front(); // issued two edges ago
				compare_writeback(exp_wb);
			end
			@(posedge clock);
		end
		if (n_lines > 0 && checks_done == n_lines) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("only %0d of %0d trace results were checked", checks_done, n_lines);
			end_with_failure();
		end
	end

	// run length bound
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_count);
			end_with_failure();
		end
	end

endmodule

`default_nettype wire

// File: logic/fx_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fx_unit (
	input  wire logic               clock_i,
	input  wire logic               rst_i,
	input  wire logic               issue_valid_i,
	input  wire fx_pkg::fx_issue_t  issue_i,
	output fx_pkg::fx_writeback_t   wb_o,
	output logic                    xer_so_o
);

	import fx_pkg::*;

	////////////////////////////////////////////////////////////
	// decode -> alu -> format, 2 cycles issue to wb
	////////////////////////////////////////////////////////////

	fx_decoded_t    decoded;    // combinational
	fx_alu_result_t alu_result; // after first edge

	fx_issue_decode u_decode (
		.clock_i       (clock_i),
		.rst_i         (rst_i),
		.issue_valid_i (issue_valid_i),
		.issue_i       (issue_i),
		.decoded_o     (decoded)
	);

	fx_alu u_alu (
		.clock_i      (clock_i),
		.rst_i        (rst_i),
		.decoded_i    (decoded),
		.alu_result_o (alu_result)
	);

	fx_writeback_format u_format (
		.clock_i      (clock_i),
		.rst_i        (rst_i),
		.alu_result_i (alu_result),
		.wb_o         (wb_o),       // to gpr / cr
		.xer_so_o     (xer_so_o)
	);

endmodule

`default_nettype wire

// File: logic/fx_writeback_format.sv
`timescale 1ns/10ps
`default_nettype none

`include "fx_defs.svh"

module fx_writeback_format (
	input  wire logic                    clock_i,
	input  wire logic                    rst_i,
	input  wire fx_pkg::fx_alu_result_t  alu_result_i,
	output fx_pkg::fx_writeback_t        wb_o,
	output logic                         xer_so_o
);

	import fx_pkg::*;

	localparam int HALF_W = `FX_DATA_W / 2;

	// fixed point exception state, kept here
	logic so_q;
	logic ov_q;
	logic ca_q;
	logic ca32_q;
	logic so_next;
	logic ov_next;
	logic ca_next;
	logic ca32_next;
	logic ov_upd;
	logic ca_upd;
	logic is_cmp;
	logic is_rec;
	logic [`FX_DATA_W-1:0] value;
	logic [`FX_DATA_W-1:0] rec_val;  // value seen by cr0
	fx_writeback_t wb_next;

	////////////////////////////////////////////////////////////
	// classify
	////////////////////////////////////////////////////////////

	assign is_cmp = (alu_result_i.op == OP_CMP_SIGNED) || (alu_result_i.op == OP_CMP_LOGICAL);
	assign is_rec = (alu_result_i.op == OP_ADD_CARRY_REC) || (alu_result_i.op == OP_AND_REC);

	assign ca_upd = alu_result_i.valid && ((alu_result_i.op == OP_ADD_CARRY) ||
		(alu_result_i.op == OP_ADD_CARRY_REC) || (alu_result_i.op == OP_SUBF_CARRY));
	assign ov_upd = 1'b0; // no OE forms among the D forms

	assign ca_next   = ca_upd ? alu_result_i.sum[`FX_DATA_W] : ca_q;
	assign ca32_next = ca_upd ? alu_result_i.carry32 : ca32_q;
	assign ov_next   = ov_upd ? alu_result_i.overflow : ov_q;
	assign so_next   = so_q | (ov_upd & alu_result_i.overflow); // sticky

	////////////////////////////////////////////////////////////
	// value and cr bits
	////////////////////////////////////////////////////////////

	assign value = (alu_result_i.op == OP_MUL_LOW) ? alu_result_i.prod_lo :
		alu_result_i.sum[`FX_DATA_W-1:0];

	// 32 bit mode looks at the low word only
	assign rec_val = alu_result_i.is64 ? value :
		{{HALF_W{value[HALF_W-1]}}, value[HALF_W-1:0]};

	always_comb begin
		wb_next.valid    = alu_result_i.valid;
		wb_next.gpr_we   = alu_result_i.valid && !is_cmp;
		wb_next.gpr_addr = alu_result_i.target;
		wb_next.value    = value;
		wb_next.cr_we    = alu_result_i.valid && (is_cmp || is_rec);
		wb_next.cr_field = is_cmp ? alu_result_i.target[`FX_REG_ADDR_W-1:2] : 3'd0; // bf or cr0
		if (is_cmp) begin
			wb_next.cr_bits = {alu_result_i.cmp_lt, alu_result_i.cmp_gt, alu_result_i.cmp_eq,
				so_next};
		end else begin
			wb_next.cr_bits = {rec_val[`FX_DATA_W-1],
				!rec_val[`FX_DATA_W-1] && (rec_val != '0),
				(rec_val == '0), so_next};
		end
		wb_next.carry    = ca_next;
		wb_next.carry32  = ca32_next;
		wb_next.overflow = ov_next;
	end

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i) begin
		wb_o <= wb_next;
		if (rst_i) begin
			wb_o.valid  <= 1'b0;
			wb_o.gpr_we <= 1'b0;
			wb_o.cr_we  <= 1'b0;
		end
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			so_q   <= 1'b0;
			ov_q   <= 1'b0;
			ca_q   <= 1'b0;
			ca32_q <= 1'b0;
		end else begin
			so_q   <= so_next;
			ov_q   <= ov_next;
			ca_q   <= ca_next;
			ca32_q <= ca32_next;
		end
	end

	assign xer_so_o = so_q;

endmodule

`default_nettype wire

// File: logic/fx_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "fx_defs.svh"

module fx_alu (
	input  wire logic                 clock_i,
	input  wire logic                 rst_i,
	input  wire fx_pkg::fx_decoded_t  decoded_i,
	output fx_pkg::fx_alu_result_t    alu_result_o
);

	import fx_pkg::*;

	localparam int HALF_W = `FX_DATA_W / 2; // word boundary for ca32

	logic [`FX_DATA_W-1:0]         add_a;     // ra, inverted for subfic
	logic                          add_cin;
	logic [`FX_DATA_W:0]           sum_full;
	logic [HALF_W:0]               low_sum;   // only its carry is kept
	logic signed [2*`FX_DATA_W-1:0] prod_full;
	logic [`FX_DATA_W:0]           res_sum;   // sum or logical result
	logic [`FX_DATA_W-1:0]         cmp_a;
	logic [`FX_DATA_W-1:0]         cmp_b;
	logic                          cmp_lt;
	logic                          cmp_gt;
	fx_alu_result_t                alu_next;

	////////////////////////////////////////////////////////////
	// adder, multiplier, logic
	////////////////////////////////////////////////////////////

	assign add_cin = (decoded_i.op == OP_SUBF_CARRY); // ~ra + imm + 1
	assign add_a   = add_cin ? ~decoded_i.operand : decoded_i.operand;

	assign sum_full = {1'b0, add_a} + {1'b0, decoded_i.imm_ext} + {{`FX_DATA_W{1'b0}}, add_cin};
	assign low_sum  = {1'b0, add_a[HALF_W-1:0]} + {1'b0, decoded_i.imm_ext[HALF_W-1:0]}
		+ {{HALF_W{1'b0}}, add_cin};

	// full signed product, low half goes to rt
	assign prod_full = $signed(decoded_i.operand) * $signed(decoded_i.imm_ext);

	always_comb begin
		case (decoded_i.op)
			OP_AND_REC: res_sum = {1'b0, decoded_i.operand & decoded_i.imm_ext};
			OP_OR:      res_sum = {1'b0, decoded_i.operand | decoded_i.imm_ext};
			OP_XOR:     res_sum = {1'b0, decoded_i.operand ^ decoded_i.imm_ext};
			default:    res_sum = sum_full; // arithmetic keeps its carry
		endcase
	end

	////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////

	always_comb begin
		if (decoded_i.cmp64) begin
			cmp_a = decoded_i.operand;
			cmp_b = decoded_i.imm_ext;
		end else if (decoded_i.op == OP_CMP_SIGNED) begin
			cmp_a = {{HALF_W{decoded_i.operand[HALF_W-1]}}, decoded_i.operand[HALF_W-1:0]};
			cmp_b = {{HALF_W{decoded_i.imm_ext[HALF_W-1]}}, decoded_i.imm_ext[HALF_W-1:0]};
		end else begin
			cmp_a = {{HALF_W{1'b0}}, decoded_i.operand[HALF_W-1:0]}; // low word only
			cmp_b = {{HALF_W{1'b0}}, decoded_i.imm_ext[HALF_W-1:0]};
		end
	end

	assign cmp_lt = (decoded_i.op == OP_CMP_SIGNED) ? ($signed(cmp_a) < $signed(cmp_b)) :
		(cmp_a < cmp_b);
	assign cmp_gt = (decoded_i.op == OP_CMP_SIGNED) ? ($signed(cmp_a) > $signed(cmp_b)) :
		(cmp_a > cmp_b);

	////////////////////////////////////////////////////////////
	// result register
	////////////////////////////////////////////////////////////

	always_comb begin
		alu_next.valid    = decoded_i.valid;
		alu_next.op       = decoded_i.op;
		alu_next.sum      = res_sum;
		alu_next.prod_lo  = prod_full[`FX_DATA_W-1:0];
		alu_next.carry32  = low_sum[HALF_W];
		// same sign in, other sign out
		alu_next.overflow = (add_a[`FX_DATA_W-1] == decoded_i.imm_ext[`FX_DATA_W-1]) &&
			(sum_full[`FX_DATA_W-1] != add_a[`FX_DATA_W-1]);
		alu_next.target   = decoded_i.target;
		alu_next.is64     = decoded_i.is64;
		alu_next.cmp_lt   = cmp_lt;
		alu_next.cmp_gt   = cmp_gt;
		alu_next.cmp_eq   = (cmp_a == cmp_b);
	end

	always_ff @(posedge clock_i) begin
		alu_result_o <= alu_next;
		if (rst_i) begin
			alu_result_o.valid <= 1'b0; // payload left as is
		end
	end

endmodule

`default_nettype wire

// File: logic/fx_issue_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "fx_defs.svh"

module fx_issue_decode (
	input  wire logic               clock_i,  // decode is combinational
	input  wire logic               rst_i,
	input  wire logic               issue_valid_i,
	input  wire fx_pkg::fx_issue_t  issue_i,
	output fx_pkg::fx_decoded_t     decoded_o
);

	import fx_pkg::*;

	////////////////////////////////////////////////////////////
	// immediate forms
	////////////////////////////////////////////////////////////

	localparam int EXT_W = `FX_DATA_W - `FX_IMM_W;     // bits added on top
	localparam int SH_W  = `FX_DATA_W - 2 * `FX_IMM_W; // top bits of a shifted imm

	logic [`FX_DATA_W-1:0] imm_sext;
	logic [`FX_DATA_W-1:0] imm_zext;
	logic [`FX_DATA_W-1:0] imm_sext_sh;
	logic [`FX_DATA_W-1:0] imm_zext_sh;
	fx_op_e                op;
	logic [`FX_DATA_W-1:0] imm_sel;

	assign imm_sext    = {{EXT_W{issue_i.imm[`FX_IMM_W-1]}}, issue_i.imm};
	assign imm_zext    = {{EXT_W{1'b0}}, issue_i.imm};
	assign imm_sext_sh = {{SH_W{issue_i.imm[`FX_IMM_W-1]}}, issue_i.imm, {`FX_IMM_W{1'b0}}};
	assign imm_zext_sh = {{SH_W{1'b0}}, issue_i.imm, {`FX_IMM_W{1'b0}}};

	////////////////////////////////////////////////////////////
	// primary opcode decode
	////////////////////////////////////////////////////////////

	always_comb begin
		op      = OP_NOP;
		imm_sel = imm_sext;
		case (issue_i.opcode)
			14: begin op = OP_ADD;           imm_sel = imm_sext;    end // addi
			15: begin op = OP_ADD;           imm_sel = imm_sext_sh; end // addis
			12: begin op = OP_ADD_CARRY;     imm_sel = imm_sext;    end // addic
			13: begin op = OP_ADD_CARRY_REC; imm_sel = imm_sext;    end // addic.
			8:  begin op = OP_SUBF_CARRY;    imm_sel = imm_sext;    end // subfic
			7:  begin op = OP_MUL_LOW;       imm_sel = imm_sext;    end // mulli
			11: begin op = OP_CMP_SIGNED;    imm_sel = imm_sext;    end // cmpi
			10: begin op = OP_CMP_LOGICAL;   imm_sel = imm_zext;    end // cmpli, unsigned imm
			28: begin op = OP_AND_REC;       imm_sel = imm_zext;    end // andi.
			29: begin op = OP_AND_REC;       imm_sel = imm_zext_sh; end // andis.
			24: begin op = OP_OR;            imm_sel = imm_zext;    end // ori
			25: begin op = OP_OR;            imm_sel = imm_zext_sh; end // oris
			26: begin op = OP_XOR;           imm_sel = imm_zext;    end // xori
			27: begin op = OP_XOR;           imm_sel = imm_zext_sh; end // xoris
			default: begin
				op      = OP_NOP; // not a D form we handle
				imm_sel = imm_zext;
			end
		endcase
	end

	// only our own unit code and a known opcode go on
	assign decoded_o.valid = issue_valid_i && (issue_i.unit_code == UNIT_FX) && (op != OP_NOP);
	assign decoded_o.op      = op;
	assign decoded_o.operand = issue_i.ra;
	assign decoded_o.imm_ext = imm_sel;
	assign decoded_o.target  = issue_i.target; // rt, or bf in [4:2]
	assign decoded_o.is64    = issue_i.is64;

	// L sits in the low target bit on a compare
	assign decoded_o.cmp64 = ((op == OP_CMP_SIGNED) || (op == OP_CMP_LOGICAL)) ?
		issue_i.target[0] : 1'b0;

endmodule

`default_nettype wire

// File: logic/fx_pkg.sv
`default_nettype none

`include "fx_defs.svh"

package fx_pkg;

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// functional unit codes used by dispatch
	typedef enum logic [`FX_UNIT_CODE_W-1:0] {
		UNIT_FX     = 3'd0,
		UNIT_FP     = 3'd1,
		UNIT_LDST   = 3'd2,
		UNIT_BRANCH = 3'd3,
		UNIT_TRAP   = 3'd4
	} fx_unit_code_e;

	// decoded D form operations
	typedef enum logic [3:0] {
		OP_ADD,          // addi, addis
		OP_ADD_CARRY,    // addic
		OP_ADD_CARRY_REC, // addic.
		OP_SUBF_CARRY,   // subfic
		OP_MUL_LOW,      // mulli
		OP_CMP_SIGNED,   // cmpi
		OP_CMP_LOGICAL,  // cmpli
		OP_AND_REC,      // andi., andis.
		OP_OR,           // ori, oris
		OP_XOR,          // xori, xoris
		OP_NOP
	} fx_op_e;

	////////////////////////////////////////////////////////////
	// stage bundles
	////////////////////////////////////////////////////////////

	// straight from dispatch
	typedef struct packed {
		fx_unit_code_e              unit_code;
		logic [`FX_OPCODE_W-1:0]    opcode;
		logic [`FX_REG_ADDR_W-1:0]  target;   // rt, or bf/0/l for compares
		logic [`FX_DATA_W-1:0]      ra;
		logic [`FX_IMM_W-1:0]       imm;
		logic                       is64;
	} fx_issue_t;

	// decode -> alu
	typedef struct packed {
		logic                       valid;
		fx_op_e                     op;
		logic [`FX_DATA_W-1:0]      operand;
		logic [`FX_DATA_W-1:0]      imm_ext;  // already extended and shifted
		logic [`FX_REG_ADDR_W-1:0]  target;
		logic                       is64;
		logic                       cmp64;    // L bit of a compare
	} fx_decoded_t;

	// alu -> formatter
	typedef struct packed {
		logic                       valid;
		fx_op_e                     op;
		logic [`FX_DATA_W:0]        sum;      // carry out in the top bit
		logic [`FX_DATA_W-1:0]      prod_lo;
		logic                       carry32;
		logic                       overflow;
		logic [`FX_REG_ADDR_W-1:0]  target;
		logic                       is64;
		logic                       cmp_lt;
		logic                       cmp_gt;
		logic                       cmp_eq;
	} fx_alu_result_t;

	// out to the register file
	typedef struct packed {
		logic                       valid;
		logic                       gpr_we;
		logic [`FX_REG_ADDR_W-1:0]  gpr_addr;
		logic [`FX_DATA_W-1:0]      value;
		logic                       cr_we;
		logic [2:0]                 cr_field;
		logic [3:0]                 cr_bits;  // lt gt eq so
		logic                       carry;
		logic                       carry32;
		logic                       overflow;
	} fx_writeback_t;

endpackage

`default_nettype wire

// File: logic/fx_defs.svh
`ifndef FX_DEFS_SVH
`define FX_DEFS_SVH

////////////////////////////////////////////////////////////
// fixed point unit widths
////////////////////////////////////////////////////////////

// operand and result width
`define FX_DATA_W 64

// gpr address, rt / ra field of the D form
`define FX_REG_ADDR_W 5

// D form immediate field
`define FX_IMM_W 16

// primary opcode, bits 0..5 of the instruction word
`define FX_OPCODE_W 6

// dispatch target code
`define FX_UNIT_CODE_W 3

`endif
